/* logic/ids_settings.svh */
// widths and depths of the packet filter, included by the RTL and the testbench
`ifndef IDS_SETTINGS_SVH
`define IDS_SETTINGS_SVH

// data path
`define IDS_DATA_W 64
`define IDS_CTRL_W 8

// per-slot buffer address bits, 256 words
`define IDS_BUF_ADDR_W 8

// input FIFO of four entries
`define IDS_FIFO_DEPTH_BITS 2
// free entries left when nearly-full rises
`define IDS_NEARLY_FULL_SLACK 1

// squash counter
`define IDS_COUNT_W 32

`endif

/* logic/ids_pkt_pkg.sv */
// packet word and pattern types, shared by the data path, the slots and the matcher
`include "ids_settings.svh"

package ids_pkt_pkg;

   // one stored or forwarded word
   // ctrl sits above the data
   typedef struct packed {
      logic [`IDS_CTRL_W-1:0] ctrl;
      logic [`IDS_DATA_W-1:0] data;
   } pkt_word_t;

   // pattern word as seen on the pattern input
   // mask bit k enables data byte k, bit 7 is ignored
   typedef struct packed {
      logic [7:0]  mask;
      logic [55:0] bytes;
   } pattern_cfg_t;

endpackage

/* logic/ids_slot_pkg.sv */
// slot FSM state and one-hot slot select types for the arbiter and the slots
package ids_slot_pkg;

   // per-slot packet FSM
   typedef enum logic [1:0] {
      SLOT_START      = 2'b00,
      SLOT_PAYLOAD    = 2'b01,
      SLOT_READ_READY = 2'b10
   } slot_state_t;

   // one-hot grant select
   typedef enum logic [1:0] {
      SEL_SLOT0 = 2'b01,
      SEL_SLOT1 = 2'b10
   } slot_sel_t;

endpackage

/* logic/slot_bus_if.sv */
// bus between the arbiter and one packet slot, one instance per slot
`timescale 1ns/1ps

interface slot_bus_if;
   import ids_pkt_pkg::*;
   import ids_slot_pkg::*;

   // driven by the arbiter
   logic        fifo_avail;
   pkt_word_t   fifo_word;
   logic        write_grant;
   logic        read_grant;
   logic        out_rdy;

   // driven by the slot
   slot_state_t state;
   logic        fifo_rd;
   logic        out_wr;
   pkt_word_t   rd_word;
   logic        squash;

   modport arb (
      output fifo_avail, fifo_word, write_grant, read_grant, out_rdy,
      input  state, fifo_rd, out_wr, rd_word, squash
   );

   modport slot (
      input  fifo_avail, fifo_word, write_grant, read_grant, out_rdy,
      output state, fifo_rd, out_wr, rd_word, squash
   );

endinterface

/* logic/input_fifo.sv */
// fall-through FIFO that buffers incoming words ahead of the packet slots
`timescale 1ns/1ps
`include "ids_settings.svh"

module input_fifo (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wr_en_i,
   input  ids_pkt_pkg::pkt_word_t din_i,
   input  logic                   rd_en_i,
   output ids_pkt_pkg::pkt_word_t dout_o,
   output logic                   empty_o,
   output logic                   nearly_full_o
);
   import ids_pkt_pkg::*;

   localparam int DEPTH_BITS = `IDS_FIFO_DEPTH_BITS;
   localparam int DEPTH      = 1 << DEPTH_BITS;
   localparam int NF_LEVEL   = DEPTH - `IDS_NEARLY_FULL_SLACK;

   pkt_word_t             fifo_mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr_r;
   logic [DEPTH_BITS-1:0] rd_ptr_r;
   logic [DEPTH_BITS:0]   count_r;
   logic                  full_w;

   // storage array
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         fifo_mem[wr_ptr_r] <= din_i;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         if (wr_en_i && !rd_en_i) begin
            count_r <= count_r + 1'b1;
         end else if (rd_en_i && !wr_en_i) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   // head word shows as soon as it lands
   assign dout_o        = fifo_mem[rd_ptr_r];
   assign empty_o       = (count_r == '0);
   assign full_w        = (count_r == (DEPTH_BITS + 1)'(DEPTH));
   assign nearly_full_o = (count_r >= (DEPTH_BITS + 1)'(NF_LEVEL));

   // upstream must honour in_rdy, the slots must honour empty
   a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en_i |-> !full_w)
      else $error("input FIFO written while full");
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en_i |-> !empty_o)
      else $error("input FIFO popped while empty");

endmodule

/* logic/worm_matcher.sv */
// masked seven-byte pattern compare with a sticky match flag per packet
`timescale 1ns/1ps

module worm_matcher (
   input  logic                      clk,
   input  logic                      reset,
   input  ids_pkt_pkg::pattern_cfg_t pattern_i,
   input  logic                      word_valid_i,
   input  ids_pkt_pkg::pkt_word_t    word_i,
   input  logic                      pkt_end_i,
   output logic                      match_o
);

   logic [6:0] byte_hit_w;
   logic       word_match_w;
   logic       match_flag_r;

   // a byte left out of the mask always hits
   always_comb begin
      for (int k = 0; k < 7; k++) begin
         byte_hit_w[k] = !pattern_i.mask[k] ||
                         (word_i.data[8*k +: 8] == pattern_i.bytes[8*k +: 8]);
      end
   end

   assign word_match_w = word_valid_i && (&byte_hit_w);

   // held for the rest of the packet, cleared as its last word goes by
   always_ff @(posedge clk) begin
      if (reset || pkt_end_i) begin
         match_flag_r <= 1'b0;
      end else if (word_match_w) begin
         match_flag_r <= 1'b1;
      end
   end

   // current word counts too
   assign match_o = match_flag_r || word_match_w;

endmodule

/* logic/packet_slot.sv */
// one packet slot that stores a packet from the input FIFO, then sends or squashes it
`timescale 1ns/1ps
`include "ids_settings.svh"

module packet_slot (
   input  logic                      clk,
   input  logic                      reset,
   input  ids_pkt_pkg::pattern_cfg_t pattern_i,
   slot_bus_if.slot                  bus
);
   import ids_pkt_pkg::*;
   import ids_slot_pkg::*;

   localparam int AW = `IDS_BUF_ADDR_W;

   slot_state_t   state_r;
   slot_state_t   state_next;
   pkt_word_t     buf_mem [2**AW];
   logic [AW-1:0] wr_ptr_r;
   logic [AW-1:0] rd_ptr_r;
   logic [AW-1:0] wr_ptr_inc_w;
   pkt_word_t     rd_word_r;
   logic          out_wr_r;
   logic          squash_r;
   logic          accept_w;
   logic          word_nz_w;
   logic          pop_w;
   logic          store_w;
   logic          pkt_end_w;
   logic          match_w;
   logic          drop_w;
   logic          rd_issue_w;

   ////////////////////
   // store side
   ////////////////////
   assign accept_w     = bus.write_grant && bus.fifo_avail && bus.out_rdy;
   assign word_nz_w    = (bus.fifo_word.ctrl != '0);
   assign wr_ptr_inc_w = wr_ptr_r + 1'b1;

   // idle words before a packet are popped and thrown away
   assign pop_w     = accept_w && (state_r == SLOT_START || state_r == SLOT_PAYLOAD);
   assign store_w   = pop_w && (state_r == SLOT_PAYLOAD || word_nz_w);
   assign pkt_end_w = pop_w && (state_r == SLOT_PAYLOAD) && word_nz_w;
   assign drop_w    = pkt_end_w && match_w;

   worm_matcher matcher_i (
      .clk          (clk),
      .reset        (reset),
      .pattern_i    (pattern_i),
      .word_valid_i (store_w),
      .word_i       (bus.fifo_word),
      .pkt_end_i    (pkt_end_w),
      .match_o      (match_w)
   );

   ////////////////////
   // read side
   ////////////////////
   assign rd_issue_w = (state_r == SLOT_READ_READY) && bus.read_grant && bus.out_rdy &&
                       (rd_ptr_r != wr_ptr_r);

   // packet FSM
   always_comb begin
      state_next = state_r;
      case (state_r)
         SLOT_START: begin
            if (store_w) begin
               state_next = SLOT_PAYLOAD;
            end
         end
         SLOT_PAYLOAD: begin
            if (pkt_end_w) begin
               state_next = match_w ? SLOT_START : SLOT_READ_READY;
            end
         end
         SLOT_READ_READY: begin
            if (rd_ptr_r == wr_ptr_r) begin
               state_next = SLOT_START;
            end
         end
         default: state_next = SLOT_START;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_r  <= SLOT_START;
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         out_wr_r <= 1'b0;
         squash_r <= 1'b0;
      end else begin
         state_r  <= state_next;
         out_wr_r <= rd_issue_w;
         squash_r <= drop_w;
         if (store_w) begin
            wr_ptr_r <= wr_ptr_inc_w;
         end
         // squash empties the buffer in one step
         if (drop_w) begin
            rd_ptr_r <= wr_ptr_inc_w;
         end else if (rd_issue_w) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
      end
   end

   // buffer memory, one cycle read
   always_ff @(posedge clk) begin
      if (store_w) begin
         buf_mem[wr_ptr_r] <= bus.fifo_word;
      end
      if (rd_issue_w) begin
         rd_word_r <= buf_mem[rd_ptr_r];
      end
   end

   assign bus.state   = state_r;
   assign bus.fifo_rd = pop_w;
   assign bus.out_wr  = out_wr_r;
   assign bus.rd_word = rd_word_r;
   assign bus.squash  = squash_r;

   // writer must never catch up with unread words
   a_no_lap: assert property (@(posedge clk) disable iff (reset)
      store_w |-> (wr_ptr_inc_w != rd_ptr_r))
      else $error("slot buffer write pointer lapped the read pointer");

   // the last read completes before the slot restarts
   a_no_out_in_start: assert property (@(posedge clk) disable iff (reset)
      out_wr_r |-> (state_r != SLOT_START))
      else $error("slot output valid while in SLOT_START");

endmodule

/* logic/slot_arbiter.sv */
// grants the shared FIFO and output bus to the two slots and counts squashed packets
`timescale 1ns/1ps
`include "ids_settings.svh"

module slot_arbiter (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    fifo_empty_i,
   input  logic                    fifo_nearly_full_i,
   input  ids_pkt_pkg::pkt_word_t  fifo_word_i,
   output logic                    fifo_rd_o,
   input  logic                    in_wr_i,
   output logic                    fifo_wr_o,
   output logic                    in_rdy_o,
   input  logic                    out_rdy_i,
   output ids_pkt_pkg::pkt_word_t  out_word_o,
   output logic                    out_wr_o,
   output logic [`IDS_COUNT_W-1:0] squash_count_o,
   slot_bus_if.arb                 slot0,
   slot_bus_if.arb                 slot1
);
   import ids_slot_pkg::*;

   slot_sel_t               wr_grant_r;
   slot_sel_t               rd_grant_r;
   logic                    wr_sel0_w;
   logic                    rd_sel0_w;
   logic                    wr_storing_w;
   logic                    wr_storing_r;
   logic                    other_start_w;
   logic                    wr_move_w;
   logic                    rd_active_w;
   logic                    rd_active_r;
   logic                    other_ready_w;
   logic                    rd_move_w;
   logic [`IDS_COUNT_W-1:0] squash_count_r;

   function automatic logic is_storing(slot_state_t s);
      return (s == SLOT_START) || (s == SLOT_PAYLOAD);
   endfunction

   assign wr_sel0_w = (wr_grant_r == SEL_SLOT0);
   assign rd_sel0_w = (rd_grant_r == SEL_SLOT0);

   ////////////////////
   // grant rules
   ////////////////////
   // writer moves on when its slot stops storing, or early if the other slot is free
   assign wr_storing_w  = wr_sel0_w ? is_storing(slot0.state) : is_storing(slot1.state);
   assign other_start_w = wr_sel0_w ? (slot1.state == SLOT_START) : (slot0.state == SLOT_START);
   assign wr_move_w     = !wr_storing_w && (wr_storing_r || other_start_w);

   assign rd_active_w   = rd_sel0_w ? (slot0.state == SLOT_READ_READY) :
                                      (slot1.state == SLOT_READ_READY);
   assign other_ready_w = rd_sel0_w ? (slot1.state == SLOT_READ_READY) :
                                      (slot0.state == SLOT_READ_READY);
   assign rd_move_w     = !rd_active_w && (rd_active_r || other_ready_w);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_grant_r     <= SEL_SLOT0;
         rd_grant_r     <= SEL_SLOT0;
         wr_storing_r   <= 1'b0;
         rd_active_r    <= 1'b0;
         squash_count_r <= '0;
      end else begin
         wr_storing_r <= wr_storing_w;
         rd_active_r  <= rd_active_w;
         if (wr_move_w) begin
            wr_grant_r <= wr_sel0_w ? SEL_SLOT1 : SEL_SLOT0;
         end
         if (rd_move_w) begin
            rd_grant_r <= rd_sel0_w ? SEL_SLOT1 : SEL_SLOT0;
         end
         // only the writer can squash, so one pulse at a time
         if (slot0.squash || slot1.squash) begin
            squash_count_r <= squash_count_r + 1'b1;
         end
      end
   end

   ////////////////////
   // FIFO and output steering
   ////////////////////
   assign slot0.write_grant = wr_sel0_w;
   assign slot1.write_grant = (wr_grant_r == SEL_SLOT1);
   assign slot0.read_grant  = rd_sel0_w;
   assign slot1.read_grant  = (rd_grant_r == SEL_SLOT1);
   assign slot0.fifo_avail  = slot0.write_grant && !fifo_empty_i;
   assign slot1.fifo_avail  = slot1.write_grant && !fifo_empty_i;
   assign slot0.fifo_word   = slot0.write_grant ? fifo_word_i : '0;
   assign slot1.fifo_word   = slot1.write_grant ? fifo_word_i : '0;
   assign slot0.out_rdy     = out_rdy_i;
   assign slot1.out_rdy     = out_rdy_i;

   assign fifo_rd_o = wr_sel0_w ? slot0.fifo_rd : slot1.fifo_rd;
   // a word held while in_rdy is low is not taken
   assign fifo_wr_o = in_wr_i && in_rdy_o;
   assign in_rdy_o  = wr_storing_w && !fifo_nearly_full_i;

   assign out_wr_o       = slot0.out_wr || slot1.out_wr;
   assign out_word_o     = slot1.out_wr ? slot1.rd_word : slot0.rd_word;
   assign squash_count_o = squash_count_r;

   a_grants_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot(wr_grant_r) && $onehot(rd_grant_r))
      else $error("slot grant lost its one-hot encoding");

endmodule

/* logic/ids_top.sv */
// top level of the two-slot packet filter, connecting the FIFO, the arbiter and the slots
`timescale 1ns/1ps
`include "ids_settings.svh"

module ids_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`IDS_DATA_W-1:0]  in_data_i,
   input  logic [`IDS_CTRL_W-1:0]  in_ctrl_i,
   input  logic                    in_wr_i,
   output logic                    in_rdy_o,
   output logic [`IDS_DATA_W-1:0]  out_data_o,
   output logic [`IDS_CTRL_W-1:0]  out_ctrl_o,
   output logic                    out_wr_o,
   input  logic                    out_rdy_i,
   input  logic [`IDS_DATA_W-1:0]  pattern_i,
   output logic [`IDS_COUNT_W-1:0] squash_count_o
);
   import ids_pkt_pkg::*;

   pkt_word_t    in_word_w;
   pkt_word_t    fifo_word_w;
   pkt_word_t    out_word_w;
   pattern_cfg_t pattern_w;
   logic         fifo_wr_w;
   logic         fifo_rd_w;
   logic         fifo_empty_w;
   logic         fifo_nearly_full_w;

   slot_bus_if slot0_bus ();
   slot_bus_if slot1_bus ();

   // pack and unpack the plain ports
   assign in_word_w  = '{ctrl: in_ctrl_i, data: in_data_i};
   assign pattern_w  = pattern_i;
   assign out_data_o = out_word_w.data;
   assign out_ctrl_o = out_word_w.ctrl;

   input_fifo in_fifo_i (
      .clk           (clk),
      .reset         (reset),
      .wr_en_i       (fifo_wr_w),
      .din_i         (in_word_w),
      .rd_en_i       (fifo_rd_w),
      .dout_o        (fifo_word_w),
      .empty_o       (fifo_empty_w),
      .nearly_full_o (fifo_nearly_full_w)
   );

   slot_arbiter arbiter_i (
      .clk                (clk),
      .reset              (reset),
      .fifo_empty_i       (fifo_empty_w),
      .fifo_nearly_full_i (fifo_nearly_full_w),
      .fifo_word_i        (fifo_word_w),
      .fifo_rd_o          (fifo_rd_w),
      .in_wr_i            (in_wr_i),
      .fifo_wr_o          (fifo_wr_w),
      .in_rdy_o           (in_rdy_o),
      .out_rdy_i          (out_rdy_i),
      .out_word_o         (out_word_w),
      .out_wr_o           (out_wr_o),
      .squash_count_o     (squash_count_o),
      .slot0              (slot0_bus.arb),
      .slot1              (slot1_bus.arb)
   );

   packet_slot slot0_i (
      .clk       (clk),
      .reset     (reset),
      .pattern_i (pattern_w),
      .bus       (slot0_bus.slot)
   );

   packet_slot slot1_i (
      .clk       (clk),
      .reset     (reset),
      .pattern_i (pattern_w),
      .bus       (slot1_bus.slot)
   );

endmodule

/* dv/tb_clock.sv */
// clock and reset source for the packet filter testbench, reset held for a few cycles
`timescale 1ns/1ps

module tb_clock #(
   parameter real PERIOD_NS    = 20.0,
   parameter int  RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   // released on a rising edge like any other input
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* dv/ids_tb.sv */
// testbench for the packet filter, random packets checked against a reference model
`timescale 1ns/1ps
`include "ids_settings.svh"

module ids_tb;

   localparam int          CLK_NS         = 20;
   localparam int          PKTS_PER_PHASE = 40;
   localparam int          MAX_PKT_LEN    = 12;
   localparam int          MAX_STRAY      = 2;
   localparam int          DRAIN_LIMIT    = 500;
   localparam int          MAX_WORDS      = 3 * PKTS_PER_PHASE * (MAX_PKT_LEN + MAX_STRAY);
   // generous cycles per word, covers back-pressure and slot turnaround
   localparam int          WATCHDOG_CYCLES = MAX_WORDS * 20 + 3 * DRAIN_LIMIT + 200;
   localparam int          WORD_W         = `IDS_CTRL_W + `IDS_DATA_W;
   localparam logic [31:0] SEED           = 32'd77462;

   logic                    clk;
   logic                    reset;
   logic [`IDS_DATA_W-1:0]  in_data_i;
   logic [`IDS_CTRL_W-1:0]  in_ctrl_i;
   logic                    in_wr_i;
   logic                    in_rdy_o;
   logic [`IDS_DATA_W-1:0]  out_data_o;
   logic [`IDS_CTRL_W-1:0]  out_ctrl_o;
   logic                    out_wr_o;
   logic                    out_rdy_i;
   logic [`IDS_DATA_W-1:0]  pattern_i;
   logic [`IDS_COUNT_W-1:0] squash_count_o;

   // reference model state
   logic [WORD_W-1:0]       exp_q[$];
   logic [WORD_W-1:0]       cur_pkt[$];
   logic [`IDS_DATA_W-1:0]  model_pattern;
   bit                      model_in_pkt;
   bit                      model_hit;
   int                      squash_exp;
   int                      out_count;
   int                      fail_count;
   int                      other_count;
   logic [31:0]             stim_state;
   logic [31:0]             stall_state;
   bit                      stall_en;

   tb_clock #(.PERIOD_NS(20.0), .RESET_CYCLES(5)) clock_i (.clk(clk), .reset(reset));

   ids_top ids_top_i (
      .clk            (clk),
      .reset          (reset),
      .in_data_i      (in_data_i),
      .in_ctrl_i      (in_ctrl_i),
      .in_wr_i        (in_wr_i),
      .in_rdy_o       (in_rdy_o),
      .out_data_o     (out_data_o),
      .out_ctrl_o     (out_ctrl_o),
      .out_wr_o       (out_wr_o),
      .out_rdy_i      (out_rdy_i),
      .pattern_i      (pattern_i),
      .squash_count_o (squash_count_o)
   );

   ////////////////////
   // random numbers and model
   ////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_stim();
      stim_state = xorshift32(stim_state);
      return stim_state;
   endfunction

   function automatic logic [63:0] random_data();
      logic [31:0] hi;
      hi = next_stim();
      return {hi, next_stim()};
   endfunction

   // every enabled byte of the low seven must equal the pattern byte
   function automatic bit word_hits(input logic [63:0] pattern, input logic [63:0] data);
      bit hit;
      hit = 1'b1;
      for (int k = 0; k < 7; k++) begin
         if (pattern[56 + k] && (data[8*k +: 8] != pattern[8*k +: 8])) begin
            hit = 1'b0;
         end
      end
      return hit;
   endfunction

   task automatic model_word(input logic [7:0] ctrl, input logic [63:0] data);
      if (!model_in_pkt) begin
         // idle words outside a packet are dropped
         if (ctrl != 8'h00) begin
            model_in_pkt = 1'b1;
            cur_pkt.delete();
            cur_pkt.push_back({ctrl, data});
            model_hit = word_hits(model_pattern, data);
         end
      end else begin
         cur_pkt.push_back({ctrl, data});
         if (word_hits(model_pattern, data)) begin
            model_hit = 1'b1;
         end
         if (ctrl != 8'h00) begin
            model_in_pkt = 1'b0;
            if (model_hit) begin
               squash_exp++;
            end else begin
               for (int i = 0; i < cur_pkt.size(); i++) begin
                  exp_q.push_back(cur_pkt[i]);
               end
            end
         end
      end
   endtask

   task automatic check_value(input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected, input string what);
      if (actual !== expected) begin
         fail_count++;
         $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic print_counts();
      $display("summary: %0d words out, %0d squashed, %0d value mismatches, %0d other errors",
               out_count, squash_exp, fail_count, other_count);
   endtask

   ////////////////////
   // stimulus
   ////////////////////
   task automatic wait_ready();
      @(negedge clk);
      while (!in_rdy_o) begin
         @(negedge clk);
      end
   endtask

   // one word, held until the filter takes it
   task automatic send_word(input logic [7:0] ctrl, input logic [63:0] data);
      wait_ready();
      @(posedge clk);
      in_wr_i   <= 1'b1;
      in_ctrl_i <= ctrl;
      in_data_i <= data;
      wait_ready();
      // taken on this edge
      @(posedge clk);
      in_wr_i <= 1'b0;
      model_word(ctrl, data);
   endtask

   task automatic run_phase(input logic [63:0] pattern, input int seed_pos);
      logic [31:0] r;
      logic [7:0]  ctrl;
      logic [63:0] data;
      int          len;
      int          strays;
      int          seed_at;
      @(posedge clk);
      pattern_i     <= pattern;
      model_pattern = pattern;
      for (int p = 0; p < PKTS_PER_PHASE; p++) begin
         r       = next_stim();
         strays  = int'(r[1:0]) % (MAX_STRAY + 1);
         len     = 2 + int'(r[15:8]) % (MAX_PKT_LEN - 1);
         seed_at = (int'(r[19:16]) % 3 == 0) ? int'(r[27:20]) % len : -1;
         for (int s = 0; s < strays; s++) begin
            data = random_data();
            // pattern byte in a stray word must not squash anything
            if (seed_pos >= 0 && r[30]) begin
               data[8*seed_pos +: 8] = pattern[8*seed_pos +: 8];
            end
            send_word(8'h00, data);
         end
         for (int i = 0; i < len; i++) begin
            data = random_data();
            if (seed_pos >= 0 && i == seed_at) begin
               data[8*seed_pos +: 8] = pattern[8*seed_pos +: 8];
            end
            ctrl = 8'h00;
            if (i == 0 || i == len - 1) begin
               r    = next_stim();
               ctrl = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
            end
            send_word(ctrl, data);
         end
      end
   endtask

   task automatic drain_and_check(input string phase);
      int waited;
      waited = 0;
      @(negedge clk);
      while ((exp_q.size() != 0 || squash_count_o != squash_exp) && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      // quiet cycles so a late extra word still lands in this phase
      repeat (8) @(negedge clk);
      check_value(squash_count_o, squash_exp, {phase, " squash count"});
      check_value(exp_q.size(), 0, {phase, " words never sent"});
   endtask

   // output side, registered outputs sampled mid-cycle
   always @(negedge clk) begin
      if (!reset && out_wr_o) begin
         out_count++;
         if (exp_q.size() == 0) begin
            other_count++;
            $display("output word %0h at %0t was not expected, no packet was waiting",
                     {out_ctrl_o, out_data_o}, $time);
         end else begin
            check_value({out_ctrl_o, out_data_o}, exp_q.pop_front(), "output word");
         end
      end
   end

   // output back-pressure, about one cycle in four
   initial begin
      out_rdy_i   = 1'b1;
      stall_state = ~SEED;
      forever begin
         @(posedge clk);
         stall_state = xorshift32(stall_state);
         out_rdy_i <= !stall_en || (stall_state[1:0] != 2'b00);
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_NS);
      other_count++;
      $display("watchdog expired at %0t, the filter stopped making progress", $time);
      print_counts();
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      logic [63:0] pat;
      int          base_squash;
      in_wr_i      = 1'b0;
      in_ctrl_i    = '0;
      in_data_i    = '0;
      pattern_i    = '0;
      stim_state   = SEED;
      stall_en     = 1'b0;
      model_in_pkt = 1'b0;
      model_hit    = 1'b0;
      squash_exp   = 0;
      out_count    = 0;
      fail_count   = 0;
      other_count  = 0;
      @(negedge clk);
      while (reset) begin
         @(negedge clk);
      end

      // quiet after reset
      repeat (8) begin
         check_value(out_wr_o, 1'b0, "out_wr_o high before any input");
         check_value(squash_count_o, '0, "squash count not zero after reset");
         check_value(in_rdy_o, 1'b1, "in_rdy_o low while idle");
         @(negedge clk);
      end
      stall_en = 1'b1;

      // no byte enabled, mask bit 7 alone, so every packet matches
      base_squash = squash_exp;
      pat         = random_data();
      pat[63:56]  = 8'h80;
      run_phase(pat, -1);
      drain_and_check("all-squash phase");
      check_value(squash_count_o - base_squash, PKTS_PER_PHASE, "all-squash phase count");

      // all seven bytes enabled, random data never hits
      base_squash = squash_exp;
      pat         = random_data();
      pat[63:56]  = 8'h7F;
      run_phase(pat, -1);
      drain_and_check("pass-through phase");
      check_value(squash_count_o - base_squash, 0, "pass-through phase squashed a packet");

      // byte 3 only, some packets carry the value
      pat         = random_data();
      pat[63:56]  = 8'h08;
      pat[31:24]  = 8'h5A;
      run_phase(pat, 3);
      drain_and_check("one-byte phase");

      print_counts();
      if (fail_count == 0 && other_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+logic
logic/ids_pkt_pkg.sv
logic/ids_slot_pkg.sv
logic/slot_bus_if.sv
logic/input_fifo.sv
logic/worm_matcher.sv
logic/packet_slot.sv
logic/slot_arbiter.sv
logic/ids_top.sv
dv/tb_clock.sv
dv/ids_tb.sv

/* Makefile */
# Verilator lint and simulation of the packet filter
VERILATOR   ?= verilator
TOP         ?= ids_tb
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
EXE         ?= ids_sim
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= -Wno-fatal
LINT_FLAGS  ?= -Wall
SOURCES     := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(EXE)

sim: $(OBJ_DIR)/$(EXE)
	./$(OBJ_DIR)/$(EXE) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
